/* files.f */
rtl/snake_pkg.sv
rtl/key_port.sv
rtl/tick_gen.sv
rtl/game_ctrl.sv
rtl/snake_body.sv
rtl/snake_top.sv
test/snake_properties.sv
test/snake_tb.sv

/* test/snake_input.txt */
# K <scan code, hex> sends one key; T <n> waits n ticks
# E <mode> <head> <x0> <y0> <x1> <y1> <x2> <y2> <x3> <y3> in decimal, mode 0 idle 1 init 2 run 3 paused 4 blank
T 1
E 0 3 0 48 1 48 2 48 3 48
T 2
E 0 3 0 48 1 48 2 48 3 48
K 1B
T 1
E 1 3 0 23 1 23 2 23 3 23
T 1
E 2 3 0 23 1 23 2 23 3 23
T 1
E 2 0 4 23 1 23 2 23 3 23
T 1
E 2 1 4 23 5 23 2 23 3 23
K 75
T 1
E 2 2 4 23 5 23 6 23 3 23
K 72
T 1
E 2 3 4 23 5 23 6 23 6 22
K 6B
T 1
E 2 0 6 21 5 23 6 23 6 22
K 6B
T 1
E 2 1 6 21 6 20 6 23 6 22
K 6B
T 1
E 2 2 6 21 6 20 6 19 6 22
T 3
E 2 1 4 19 3 19 6 19 5 19
K 4D
T 1
E 3 2 4 19 3 19 2 19 5 19
T 3
E 3 2 4 19 3 19 2 19 5 19
K 2D
T 1
E 2 2 4 19 3 19 2 19 5 19
T 1
E 2 3 4 19 3 19 2 19 1 19
K 76
T 1
E 4 3 4 19 3 19 2 19 1 19
T 2
K 5A
T 1
E 4 3 4 19 3 19 2 19 1 19
K 1B
T 1
E 1 3 0 23 1 23 2 23 3 23
T 1
E 2 3 0 23 1 23 2 23 3 23
K 75
T 1
E 2 0 4 23 1 23 2 23 3 23
T 3
E 2 3 4 23 4 22 4 21 4 20
K 6B
T 1
E 2 0 4 19 4 22 4 21 4 20
T 4
E 2 0 0 19 3 19 2 19 1 19
T 2
E 2 2 0 19 127 19 126 19 1 19

/* test/snake_tb.sv */
// run from the project root so test/snake_input.txt is found; keys must start right after a tick
`timescale 1ns/1ps

module snake_tb;
    import snake_pkg::*;

    localparam int unsigned TICK_DIV   = 16;
    localparam int unsigned WAIT_LIMIT = 64;  // cycles per wait

    logic       main_clk;
    logic       rst;
    logic       key_req;
    scan_code_t key_code;
    logic       key_ack;
    logic       tick;
    game_mode_e game_mode;
    seg_idx_t   head_idx;
    body_t      body;

    int unsigned since_tick;  // cycles since reset or the last tick

    snake_top #(
        .TICK_DIV (TICK_DIV)
    ) u_snake_top (
        .main_clk  (main_clk),
        .rst       (rst),
        .key_req   (key_req),
        .key_code  (key_code),
        .key_ack   (key_ack),
        .tick      (tick),
        .game_mode (game_mode),
        .head_idx  (head_idx),
        .body      (body)
    );

    always #50 main_clk = ~main_clk;  // 100 ns period

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // returns on the edge that ends the tick cycle
    task automatic wait_tick();
        int unsigned n;
        logic        seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge main_clk);
            seen = tick;
            n++;
            if (!seen && n >= WAIT_LIMIT) begin
                $display("timeout: no tick within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
        end
        @(posedge main_clk);
    endtask

    task automatic wait_ack(input logic level);
        int unsigned n;
        logic        seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge main_clk);
            seen = (key_ack === level);
            n++;
            if (!seen && n >= WAIT_LIMIT) begin
                $display("timeout: key_ack did not go to %0b within %0d cycles", level, WAIT_LIMIT);
                abort_run();
            end
        end
    endtask

    task automatic send_key(input scan_code_t code);
        @(posedge main_clk);
        key_req  <= 1'b1;
        key_code <= code;
        wait_ack(1'b1);
        @(posedge main_clk);
        key_req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic check_mode(input game_mode_e exp);
        if (game_mode !== exp) begin
            $display("MISMATCH game_mode: expected %h, got %h", exp, game_mode);
            abort_run();
        end
    endtask

    task automatic check_head(input seg_idx_t exp);
        if (head_idx !== exp) begin
            $display("MISMATCH head_idx: expected %h, got %h", exp, head_idx);
            abort_run();
        end
    endtask

    task automatic check_body(input body_t exp);
        if (body !== exp) begin
            $display("MISMATCH body: expected %h, got %h", exp, body);
            abort_run();
        end
    endtask

    task automatic check_tick(input logic exp);
        if (tick !== exp) begin
            $display("MISMATCH tick: expected %h, got %h", exp, tick);
            abort_run();
        end
    endtask

    // tick due on every TICK_DIV-th cycle after reset
    always @(negedge main_clk) begin
        if (rst !== 1'b0) begin
            since_tick = 0;
        end else begin
            since_tick = since_tick + 1;
            check_tick(since_tick == TICK_DIV);
            if (since_tick == TICK_DIV) begin
                since_tick = 0;
            end
        end
        if (u_snake_top.u_props.assert_errors != 0) begin
            $display("an assertion in snake_properties failed");
            abort_run();
        end
    end

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 8'h0a && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    initial begin
        int         fd;
        int         rc;
        int         kind;
        int         count;
        int         i;
        int         vals [10];
        scan_code_t code;
        body_t      exp_body;
        logic       done;

        main_clk = 1'b0;
        rst      = 1'b1;
        key_req  = 1'b0;
        key_code = '0;

        fd = $fopen("test/snake_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file test/snake_input.txt");
            abort_run();
        end

        repeat (5) @(posedge main_clk);
        rst <= 1'b0;

        done = 1'b0;
        while (!done) begin
            rc = $fscanf(fd, " %c", kind);
            if (rc != 1) begin
                done = 1'b1;  // end of file
            end else begin
                case (kind)
                    "#": skip_line(fd);
                    "K": begin
                        rc = $fscanf(fd, "%h", code);
                        if (rc != 1) begin
                            $display("key record without a scan code");
                            abort_run();
                        end else begin
                            send_key(code);
                        end
                    end
                    "T": begin
                        rc = $fscanf(fd, "%d", count);
                        if (rc != 1) begin
                            $display("wait record without a tick count");
                            abort_run();
                        end else begin
                            repeat (count) wait_tick();
                        end
                    end
                    "E": begin
                        rc = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d",
                                     vals[0], vals[1], vals[2], vals[3], vals[4],
                                     vals[5], vals[6], vals[7], vals[8], vals[9]);
                        if (rc != 10) begin
                            $display("expected-state record is incomplete");
                            abort_run();
                        end else begin
                            for (i = 0; i < SEG_COUNT; i++) begin
                                exp_body[i].x = coord_t'(vals[2 + 2 * i]);
                                exp_body[i].y = coord_t'(vals[3 + 2 * i]);
                            end
                            @(negedge main_clk);  // mid-cycle, outputs settled
                            check_mode(game_mode_e'(vals[0][2:0]));
                            check_head(seg_idx_t'(vals[1]));
                            check_body(exp_body);
                        end
                    end
                    default: begin
                        $display("unknown record type in the stimulus file");
                        abort_run();
                    end
                endcase
            end
        end
        $fclose(fd);

        if (u_snake_top.u_props.assert_errors == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures", u_snake_top.u_props.assert_errors);
            abort_run();
        end
    end

endmodule

/* test/snake_properties.sv */
// checks assume the key source holds key_req until key_ack; failures are also counted for the testbench
`timescale 1ns/1ps

module snake_properties (
    input logic                main_clk,
    input logic                rst,
    input logic                key_req,
    input logic                key_ack,
    input logic                tick,
    input snake_pkg::body_t    body,
    input snake_pkg::seg_idx_t head_idx
);
    int unsigned assert_errors = 0;

    ack_rise_with_req: assert property (@(posedge main_clk) disable iff (rst)
        $rose(key_ack) |-> key_req)
    else begin
        $error("key_ack rose while key_req was low");
        assert_errors++;
    end

    ack_fall_without_req: assert property (@(posedge main_clk) disable iff (rst)
        $fell(key_ack) |-> !key_req)
    else begin
        $error("key_ack fell while key_req was high");
        assert_errors++;
    end

    // one-cycle pulse
    tick_single_cycle: assert property (@(posedge main_clk) disable iff (rst)
        tick |=> !tick)
    else begin
        $error("tick high on two consecutive cycles");
        assert_errors++;
    end

    body_only_on_tick: assert property (@(posedge main_clk) disable iff (rst)
        !tick |=> ($stable(body) && $stable(head_idx)))
    else begin
        $error("body or head_idx changed outside a tick");
        assert_errors++;
    end

endmodule

bind snake_top snake_properties u_props (
    .main_clk (main_clk),
    .rst      (rst),
    .key_req  (key_req),
    .key_ack  (key_ack),
    .tick     (tick),
    .body     (body),
    .head_idx (head_idx)
);

/* rtl/snake_top.sv */
// game core only; scan codes come in parallel and the display blanks while mode is blank
`timescale 1ns/1ps

module snake_top #(
    parameter int unsigned TICK_DIV = 10_000_000  // main_clk cycles per game step
) (
    input  logic                  main_clk,
    input  logic                  rst,
    input  logic                  key_req,
    input  snake_pkg::scan_code_t key_code,
    output logic                  key_ack,
    output logic                  tick,
    output snake_pkg::game_mode_e game_mode,
    output snake_pkg::seg_idx_t   head_idx,
    output snake_pkg::body_t      body
);
    import snake_pkg::*;

    key_cmd_e  pending_cmd;
    move_req_t move_req;

    key_port u_key_port (
        .main_clk    (main_clk),
        .rst         (rst),
        .key_req     (key_req),
        .key_code    (key_code),
        .key_ack     (key_ack),
        .tick        (tick),
        .pending_cmd (pending_cmd)
    );

    tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_tick_gen (
        .main_clk (main_clk),
        .rst      (rst),
        .tick     (tick)
    );

    game_ctrl u_game_ctrl (
        .main_clk    (main_clk),
        .rst         (rst),
        .tick        (tick),
        .pending_cmd (pending_cmd),
        .game_mode   (game_mode),
        .move_req    (move_req)
    );

    snake_body u_snake_body (
        .main_clk (main_clk),
        .rst      (rst),
        .tick     (tick),
        .move_req (move_req),
        .body     (body),
        .head_idx (head_idx)
    );

endmodule

/* rtl/snake_body.sv */
// four cells in a ring; the tail slot becomes the new head on each step, coordinates wrap at 128
`timescale 1ns/1ps

module snake_body (
    input  logic                 main_clk,
    input  logic                 rst,
    input  logic                 tick,
    input  snake_pkg::move_req_t move_req,
    output snake_pkg::body_t     body,
    output snake_pkg::seg_idx_t  head_idx
);
    import snake_pkg::*;

    body_t    cells;
    seg_idx_t head;
    seg_idx_t tail;
    cell_t    next_cell;

    function automatic body_t row_layout(input coord_t row);
        body_t b;
        for (int i = 0; i < SEG_COUNT; i++) begin
            b[i].x = coord_t'(i);
            b[i].y = row;
        end
        return b;
    endfunction

    always_comb begin
        next_cell = cells[head];
        case (move_req.heading)
            head_up:    next_cell.y = cells[head].y - coord_t'(1);
            head_down:  next_cell.y = cells[head].y + coord_t'(1);
            head_left:  next_cell.x = cells[head].x - coord_t'(1);
            default:    next_cell.x = cells[head].x + coord_t'(1);
        endcase
    end

    always_ff @(posedge main_clk) begin
        if (rst) begin
            cells <= row_layout(IDLE_ROW);
            head  <= seg_idx_t'(SEG_COUNT - 1);
            tail  <= '0;
        end else if (tick && move_req.load) begin
            cells <= row_layout(INIT_ROW);
            head  <= seg_idx_t'(SEG_COUNT - 1);
            tail  <= '0;
        end else if (tick && move_req.step) begin
            cells[tail] <= next_cell;  // old tail reused as head
            head        <= tail;
            tail        <= tail + seg_idx_t'(1);
        end
    end

    assign body     = cells;
    assign head_idx = head;

endmodule

/* rtl/game_ctrl.sv */
// mode FSM and heading advance only on tick; escape outranks start, turns lock out for three ticks
`timescale 1ns/1ps

module game_ctrl (
    input  logic                  main_clk,
    input  logic                  rst,
    input  logic                  tick,
    input  snake_pkg::key_cmd_e   pending_cmd,
    output snake_pkg::game_mode_e game_mode,
    output snake_pkg::move_req_t  move_req
);
    import snake_pkg::*;

    localparam int unsigned LOCK_W = $clog2(TURN_LOCKOUT + 1);

    game_mode_e         mode;
    heading_e           heading;
    logic [LOCK_W-1:0]  lockout;

    heading_e           cmd_heading;
    logic               is_turn;
    logic               turn_ok;
    logic               leave_run;

    function automatic logic is_vertical(input heading_e h);
        return (h == head_up) || (h == head_down);
    endfunction

    always_comb begin
        is_turn     = 1'b1;
        cmd_heading = heading;
        case (pending_cmd)
            cmd_up:    cmd_heading = head_up;
            cmd_down:  cmd_heading = head_down;
            cmd_left:  cmd_heading = head_left;
            cmd_right: cmd_heading = head_right;
            default:   is_turn = 1'b0;
        endcase
    end

    // parallel keys and reversals do nothing
    assign turn_ok = is_turn && (is_vertical(cmd_heading) != is_vertical(heading));

    assign leave_run = (pending_cmd == cmd_esc) || (pending_cmd == cmd_start);

    always_ff @(posedge main_clk) begin
        if (rst) begin
            mode    <= mode_idle;
            heading <= head_right;
            lockout <= '0;
        end else if (tick) begin
            if (pending_cmd == cmd_esc) begin
                mode <= mode_blank;
            end else if (pending_cmd == cmd_start) begin
                mode <= mode_init;
            end else begin
                case (mode)
                    mode_init: begin
                        mode    <= mode_run;
                        heading <= head_right;
                        lockout <= '0;
                    end
                    mode_run: begin
                        if (lockout != '0) begin
                            lockout <= lockout - LOCK_W'(1);  // pause and turns ignored
                        end else if (pending_cmd == cmd_pause) begin
                            mode <= mode_paused;
                        end else if (turn_ok) begin
                            heading <= cmd_heading;
                            lockout <= LOCK_W'(TURN_LOCKOUT);
                        end
                    end
                    mode_paused: begin
                        if (pending_cmd == cmd_resume) begin
                            mode <= mode_run;
                        end
                    end
                    default: begin
                        mode <= mode;  // idle and blank wait for start
                    end
                endcase
            end
        end
    end

    assign game_mode = mode;

    // a pending start raises load too, so the start layout lands on the tick entering init
    always_comb begin
        move_req.load    = (mode == mode_init) || (pending_cmd == cmd_start);
        move_req.step    = (mode == mode_run) && !leave_run;
        move_req.heading = heading;  // value before this tick's command
    end

endmodule

/* rtl/tick_gen.sv */
// one-cycle tick every TICK_DIV cycles, first one on cycle TICK_DIV after reset; TICK_DIV >= 2
`timescale 1ns/1ps

module tick_gen #(
    parameter int unsigned TICK_DIV = 16
) (
    input  logic main_clk,
    input  logic rst,
    output logic tick
);
    localparam int unsigned CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge main_clk) begin
        if (rst) begin
            cnt <= CNT_W'(TICK_DIV - 1);
        end else if (cnt == '0) begin
            cnt <= CNT_W'(TICK_DIV - 1);  // reload
        end else begin
            cnt <= cnt - CNT_W'(1);
        end
    end

    assign tick = (cnt == '0);

endmodule

/* rtl/key_port.sv */
// scan codes arrive parallel on a four-phase req/ack port; one pending command, newest wins
`timescale 1ns/1ps

module key_port (
    input  logic                  main_clk,
    input  logic                  rst,
    input  logic                  key_req,
    input  snake_pkg::scan_code_t key_code,
    output logic                  key_ack,
    input  logic                  tick,
    output snake_pkg::key_cmd_e   pending_cmd
);
    import snake_pkg::*;

    key_cmd_e decoded;
    logic     new_key;

    always_comb begin
        case (key_code)
            CODE_START:  decoded = cmd_start;
            CODE_ESC:    decoded = cmd_esc;
            CODE_PAUSE:  decoded = cmd_pause;
            CODE_RESUME: decoded = cmd_resume;
            CODE_UP:     decoded = cmd_up;
            CODE_DOWN:   decoded = cmd_down;
            CODE_LEFT:   decoded = cmd_left;
            CODE_RIGHT:  decoded = cmd_right;
            default:     decoded = cmd_none;  // acked, otherwise dropped
        endcase
    end

    assign new_key = key_req && !key_ack;  // first sample of a request

    // ack follows req one cycle late, which gives both edges of the handshake
    always_ff @(posedge main_clk) begin
        if (rst) begin
            key_ack <= 1'b0;
        end else begin
            key_ack <= key_req;
        end
    end

    always_ff @(posedge main_clk) begin
        if (rst) begin
            pending_cmd <= cmd_none;
        end else if (new_key && decoded != cmd_none) begin
            pending_cmd <= decoded;  // beats the tick clear
        end else if (tick) begin
            pending_cmd <= cmd_none;  // consumed by game_ctrl
        end
    end

endmodule

/* rtl/snake_pkg.sv */
// shared game types; four segments and 7-bit wrapping coordinates are fixed here
package snake_pkg;

    typedef logic [6:0] coord_t;  // wraps modulo 128

    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_t;

    localparam int unsigned SEG_COUNT = 4;

    typedef logic [$clog2(SEG_COUNT)-1:0] seg_idx_t;

    typedef cell_t [SEG_COUNT-1:0] body_t;  // indexed by slot

    typedef logic [7:0] scan_code_t;

    localparam scan_code_t CODE_START  = 8'h1B;
    localparam scan_code_t CODE_ESC    = 8'h76;
    localparam scan_code_t CODE_PAUSE  = 8'h4D;
    localparam scan_code_t CODE_RESUME = 8'h2D;
    localparam scan_code_t CODE_UP     = 8'h75;
    localparam scan_code_t CODE_DOWN   = 8'h72;
    localparam scan_code_t CODE_RIGHT  = 8'h74;
    localparam scan_code_t CODE_LEFT   = 8'h6B;

    typedef enum logic [3:0] {
        cmd_none   = 4'd0,
        cmd_start  = 4'd1,
        cmd_esc    = 4'd2,
        cmd_pause  = 4'd3,
        cmd_resume = 4'd4,
        cmd_up     = 4'd5,
        cmd_down   = 4'd6,
        cmd_left   = 4'd7,
        cmd_right  = 4'd8
    } key_cmd_e;

    typedef enum logic [2:0] {
        mode_idle   = 3'd0,
        mode_init   = 3'd1,
        mode_run    = 3'd2,
        mode_paused = 3'd3,
        mode_blank  = 3'd4  // display dark
    } game_mode_e;

    typedef enum logic [1:0] {
        head_up    = 2'd0,
        head_down  = 2'd1,
        head_left  = 2'd2,
        head_right = 2'd3
    } heading_e;

    typedef struct packed {
        logic     load;     // start layout
        logic     step;     // advance one cell
        heading_e heading;
    } move_req_t;

    // rows of the two fixed layouts, slot i sits at x = i
    localparam coord_t IDLE_ROW = 7'd48;
    localparam coord_t INIT_ROW = 7'd23;

    localparam int unsigned TURN_LOCKOUT = 3;  // ticks

endpackage
